// ==== verilog/imem_bus_pkg.sv ====
`default_nettype none

// types seen on the instruction bus side
package imem_bus_pkg;

	// byte address of an instruction fetch
	typedef logic [31:0] addr_t;

	// raw instruction word as returned by memory
	typedef logic [31:0] word_t;

	// error code returned with every response
	typedef enum logic [1:0]
	{
		RESP_OK        = 2'b00, // normal fetch
		RESP_UNALIGNED = 2'b01, // pc not word aligned
		RESP_BUS_ERR   = 2'b10, // bus access fault
		RESP_TIMEOUT   = 2'b11  // no response from slave
	} resp_err_t;

	// responses come back in request order
	// at least one cycle after acceptance
	// and the bus never applies back-pressure on them

endpackage

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

// constants and records used inside the fetch unit
package fetch_pkg;

	// entries per buffer and upper bound on credits
	localparam int FETCH_BUF_DEPTH = 3;

	// width of the running instruction id
	localparam int INST_ID_WIDTH = 4;

	// running id tagged onto every good result
	typedef logic [INST_ID_WIDTH-1:0] inst_id_t;

	// requests in flight plus results held
	typedef logic [$clog2(FETCH_BUF_DEPTH+1)-1:0] credit_t;

	// tag kept for each accepted request until its response returns
	typedef struct packed
	{
		imem_bus_pkg::addr_t pc; // address that was requested
		logic                epoch; // epoch at acceptance
	} inflight_t;

	// record handed to the decode stage
	typedef struct packed
	{
		imem_bus_pkg::addr_t     pc; // pc of this instruction
		imem_bus_pkg::word_t     inst; // fetched word
		imem_bus_pkg::resp_err_t err; // bus error code
		logic                    jump; // predicted taken
		inst_id_t                id; // running instruction id
	} fetch_res_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_fifo #(
	parameter type payload_t = logic
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic             clear_i, // drops every entry
	input  logic             push_i,
	input  payload_t         push_data_i,
	input  logic             pop_i,
	output payload_t         head_o,
	output logic             not_empty_o,
	output fetch_pkg::credit_t count_o
);

	import fetch_pkg::*;

	typedef logic [$clog2(FETCH_BUF_DEPTH)-1:0] ptr_t;

	payload_t mem [FETCH_BUF_DEPTH]; // register storage
	ptr_t     wptr_q; // next slot to write
	ptr_t     rptr_q; // oldest entry
	ptr_t     wptr_nxt;
	ptr_t     rptr_nxt;
	credit_t  count_q; // entries held
	logic     do_pop;

	// pop on an empty buffer is ignored
	assign do_pop = pop_i & not_empty_o;

	// pointers wrap at the last entry
	assign wptr_nxt = (wptr_q == ptr_t'(FETCH_BUF_DEPTH - 1)) ? '0 : wptr_q + ptr_t'(1);
	assign rptr_nxt = (rptr_q == ptr_t'(FETCH_BUF_DEPTH - 1)) ? '0 : rptr_q + ptr_t'(1);

	assign head_o      = mem[rptr_q];
	assign not_empty_o = (count_q != '0);
	assign count_o     = count_q;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wptr_q  <= '0;
			rptr_q  <= '0;
			count_q <= '0;
		end
		else if (clear_i)
		begin
			// clear wins over push and pop
			wptr_q  <= '0;
			rptr_q  <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push_i)
				wptr_q <= wptr_nxt;
			if (do_pop)
				rptr_q <= rptr_nxt;
			count_q <= count_q + credit_t'(push_i) - credit_t'(do_pop);
		end
	end

	// payload storage
	always_ff @(posedge clk)
	begin
		if (push_i && !clear_i)
			mem[wptr_q] <= push_data_i;
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_req_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_req_ctrl (
	input  logic                clk,
	input  logic                resetn,
	input  logic                rst_req_i, // one cycle pulse
	input  logic                flush_req_i, // one cycle pulse
	input  imem_bus_pkg::addr_t flush_addr_i,
	input  imem_bus_pkg::addr_t new_pc_i, // from pc generator
	input  logic                imem_req_ready_i,
	input  logic                inst_good_i, // good response this cycle
	input  logic                resp_drop_i, // stale response this cycle
	input  logic                res_pop_i, // result taken by decode
	input  fetch_pkg::credit_t  res_count_i, // results held
	output logic                rst_ack_o,
	output logic                flush_ack_o,
	output logic                to_rst_o,
	output logic                to_flush_o,
	output imem_bus_pkg::addr_t flush_addr_hold_o,
	output imem_bus_pkg::addr_t now_pc_o,
	output logic                imem_req_valid_o,
	output logic                req_fire_o,
	output logic                clear_o,
	output logic                cur_epoch_o,
	output logic                stall_inst_o
);

	import imem_bus_pkg::*;
	import fetch_pkg::*;

	logic    rst_pend_q; // reset request not yet issued
	logic    flush_pend_q; // flush request not yet issued
	logic    stall_pend_q; // good inst waiting for its next request
	logic    epoch_q;
	credit_t credit_q; // in flight plus held
	credit_t credit_nxt;
	logic    credit_ok; // room for one more request
	logic    redirect; // reset or flush in progress
	addr_t   pc_q;
	addr_t   flush_addr_q;

	assign redirect = to_rst_o | to_flush_o;

	// pulses are stretched until the bus accepts the request
	assign to_rst_o   = rst_req_i | rst_pend_q;
	assign to_flush_o = flush_req_i | flush_pend_q;

	// result buffer is emptied on any new request pulse
	assign clear_o = rst_req_i | flush_req_i;

	assign credit_ok = (credit_q < credit_t'(FETCH_BUF_DEPTH));

	// valid follows its cause in the same cycle
	assign imem_req_valid_o = credit_ok & (redirect | inst_good_i | stall_pend_q);
	assign req_fire_o       = imem_req_valid_o & imem_req_ready_i;

	assign rst_ack_o   = to_rst_o & req_fire_o;
	assign flush_ack_o = to_flush_o & req_fire_o;

	// epoch the next accepted request belongs to
	// flips early so the redirect request is already current
	assign cur_epoch_o = epoch_q ^ redirect;

	assign flush_addr_hold_o = flush_req_i ? flush_addr_i : flush_addr_q;
	assign now_pc_o          = pc_q;
	assign stall_inst_o      = stall_pend_q;

	// accepted minus consumed minus dropped
	// held results are handed back on clear
	assign credit_nxt = credit_q + credit_t'(req_fire_o) - credit_t'(res_pop_i) -
		credit_t'(resp_drop_i) - (clear_o ? res_count_i : credit_t'(0));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			rst_pend_q   <= 1'b0;
			flush_pend_q <= 1'b0;
			stall_pend_q <= 1'b0;
		end
		else
		begin
			rst_pend_q <= (rst_pend_q | rst_req_i) & ~req_fire_o;
			// a reset request cancels a waiting flush
			flush_pend_q <= (flush_pend_q ? ~rst_req_i : flush_req_i) & ~req_fire_o;
			// normal request waits on credits or ready
			stall_pend_q <= (stall_pend_q | inst_good_i) & ~redirect & ~req_fire_o;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			credit_q <= '0;
			epoch_q  <= 1'b0;
		end
		else
		begin
			credit_q <= credit_nxt;
			if (req_fire_o && redirect)
				epoch_q <= ~epoch_q; // older requests become stale
		end
	end

	// pc of the last accepted request
	always_ff @(posedge clk)
	begin
		if (req_fire_o)
			pc_q <= new_pc_i;
	end

	// target kept for the pc generator while flush waits
	always_ff @(posedge clk)
	begin
		if (flush_req_i)
			flush_addr_q <= flush_addr_i;
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_resp_filter.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_resp_filter (
	input  logic                    clk,
	input  logic                    resetn,
	input  imem_bus_pkg::word_t     imem_resp_rdata_i,
	input  imem_bus_pkg::resp_err_t imem_resp_err_i,
	input  logic                    imem_resp_valid_i,
	input  fetch_pkg::inflight_t    tag_i, // oldest in-flight request
	input  logic                    cur_epoch_i,
	input  logic                    to_rst_i,
	input  logic                    to_flush_i,
	input  logic                    stall_inst_i, // next request held back
	input  logic                    to_jump_i, // prediction for this inst
	output logic                    inst_good_o,
	output logic                    resp_drop_o,
	output fetch_pkg::fetch_res_t   res_rec_o,
	output imem_bus_pkg::word_t     now_inst_o
);

	import imem_bus_pkg::*;
	import fetch_pkg::*;

	logic     stale; // issued before the last redirect
	logic     busy; // redirect still waiting
	word_t    inst_q; // last response word
	inst_id_t id_q;

	assign stale = (tag_i.epoch != cur_epoch_i);
	assign busy  = to_rst_i | to_flush_i;

	assign inst_good_o = imem_resp_valid_i & ~stale & ~busy;
	assign resp_drop_o = imem_resp_valid_i & (stale | busy);

	// predecoder sees the live word or the held one
	assign now_inst_o = stall_inst_i ? inst_q : imem_resp_rdata_i;

	// record pushed into the result buffer
	always_comb
	begin
		res_rec_o.pc   = tag_i.pc;
		res_rec_o.inst = imem_resp_rdata_i;
		res_rec_o.err  = imem_resp_err_i;
		res_rec_o.jump = to_jump_i; // sampled with the response
		res_rec_o.id   = id_q;
	end

	// hold every response word
	always_ff @(posedge clk)
	begin
		if (imem_resp_valid_i)
			inst_q <= imem_resp_rdata_i;
	end

	// one id per good result
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			id_q <= '0;
		else if (inst_good_o)
			id_q <= id_q + inst_id_t'(1);
	end

endmodule

`default_nettype wire

// ==== verilog/imem_fetch_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module imem_fetch_ctrl (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    rst_req_i,
	input  logic                    flush_req_i,
	input  imem_bus_pkg::addr_t     flush_addr_i,
	output logic                    rst_ack_o,
	output logic                    flush_ack_o,
	output logic                    to_rst_o,
	output logic                    to_flush_o,
	output imem_bus_pkg::addr_t     flush_addr_hold_o,
	output imem_bus_pkg::addr_t     now_pc_o,
	output imem_bus_pkg::word_t     now_inst_o,
	input  imem_bus_pkg::addr_t     new_pc_i,
	input  logic                    to_jump_i,
	output imem_bus_pkg::addr_t     imem_req_addr_o,
	output logic                    imem_req_valid_o,
	input  logic                    imem_req_ready_i,
	input  imem_bus_pkg::word_t     imem_resp_rdata_i,
	input  imem_bus_pkg::resp_err_t imem_resp_err_i,
	input  logic                    imem_resp_valid_i,
	output fetch_pkg::fetch_res_t   if_res_o,
	output logic                    if_res_valid_o,
	input  logic                    if_res_ready_i
);

	import fetch_pkg::*;

	logic       req_fire, cur_epoch, stall_inst, clear;
	logic       inst_good, resp_drop, res_pop, res_not_empty;
	credit_t    res_count;
	inflight_t  tag_push, tag_head;
	fetch_res_t res_rec;

	assign imem_req_addr_o = new_pc_i; // pc generator addresses the bus
	assign tag_push        = '{pc: new_pc_i, epoch: cur_epoch};
	assign if_res_valid_o  = res_not_empty & ~clear; // nothing leaves while clearing
	assign res_pop         = if_res_valid_o & if_res_ready_i;

	fetch_req_ctrl u_req_ctrl (
		.clk               (clk),
		.resetn            (resetn),
		.rst_req_i         (rst_req_i),
		.flush_req_i       (flush_req_i),
		.flush_addr_i      (flush_addr_i),
		.new_pc_i          (new_pc_i),
		.imem_req_ready_i  (imem_req_ready_i),
		.inst_good_i       (inst_good),
		.resp_drop_i       (resp_drop),
		.res_pop_i         (res_pop),
		.res_count_i       (res_count),
		.rst_ack_o         (rst_ack_o),
		.flush_ack_o       (flush_ack_o),
		.to_rst_o          (to_rst_o),
		.to_flush_o        (to_flush_o),
		.flush_addr_hold_o (flush_addr_hold_o),
		.now_pc_o          (now_pc_o),
		.imem_req_valid_o  (imem_req_valid_o),
		.req_fire_o        (req_fire),
		.clear_o           (clear),
		.cur_epoch_o       (cur_epoch),
		.stall_inst_o      (stall_inst)
	);

	// tags of accepted requests, popped by each response
	fetch_fifo #(.payload_t(inflight_t)) fifo_tag (
		.clk         (clk),
		.resetn      (resetn),
		.clear_i     (1'b0),
		.push_i      (req_fire),
		.push_data_i (tag_push),
		.pop_i       (imem_resp_valid_i),
		.head_o      (tag_head),
		.not_empty_o (),
		.count_o     ()
	);

	fetch_resp_filter u_resp_filter (
		.clk               (clk),
		.resetn            (resetn),
		.imem_resp_rdata_i (imem_resp_rdata_i),
		.imem_resp_err_i   (imem_resp_err_i),
		.imem_resp_valid_i (imem_resp_valid_i),
		.tag_i             (tag_head),
		.cur_epoch_i       (cur_epoch),
		.to_rst_i          (to_rst_o),
		.to_flush_i        (to_flush_o),
		.stall_inst_i      (stall_inst),
		.to_jump_i         (to_jump_i),
		.inst_good_o       (inst_good),
		.resp_drop_o       (resp_drop),
		.res_rec_o         (res_rec),
		.now_inst_o        (now_inst_o)
	);

	// good results waiting for decode
	fetch_fifo #(.payload_t(fetch_res_t)) fifo_res (
		.clk         (clk),
		.resetn      (resetn),
		.clear_i     (clear),
		.push_i      (inst_good),
		.push_data_i (res_rec),
		.pop_i       (res_pop),
		.head_o      (if_res_o),
		.not_empty_o (res_not_empty),
		.count_o     (res_count)
	);

endmodule

`default_nettype wire

// ==== testbench/imem_fetch_ctrl_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module imem_fetch_ctrl_chk (
	input logic               clk,
	input logic               resetn,
	input logic               rst_req_i,
	input logic               flush_req_i,
	input logic               rst_ack_o,
	input logic               flush_ack_o,
	input logic               imem_req_valid_o,
	input logic               imem_req_ready_i,
	input logic               imem_resp_valid_i,
	input logic               if_res_valid_o,
	input fetch_pkg::credit_t res_count_i
);

	import fetch_pkg::*;

	logic       fire;
	logic       rst_wait_q; // reset pulse seen, bus has not taken it yet
	logic [2:0] out_q; // requests on the bus without a response yet

	assign fire = imem_req_valid_o & imem_req_ready_i;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			out_q      <= '0;
			rst_wait_q <= 1'b0;
		end
		else
		begin
			out_q      <= out_q + {2'b00, fire} - {2'b00, imem_resp_valid_i};
			rst_wait_q <= (rst_wait_q | rst_req_i) & ~fire;
		end
	end

	// held results plus outstanding requests
	assert property (@(posedge clk) disable iff (!resetn)
		({2'b00, res_count_i} + {1'b0, out_q}) <= 4'(FETCH_BUF_DEPTH))
		else $error("credit count above buffer depth");

	assert property (@(posedge clk) disable iff (!resetn)
		(rst_req_i | flush_req_i) |-> !if_res_valid_o)
		else $error("result valid during clear");

	// reset ack exactly when the stretched reset request is taken
	assert property (@(posedge clk) disable iff (!resetn)
		rst_ack_o == (fire & (rst_req_i | rst_wait_q)))
		else $error("reset ack does not match the accepted reset request");

	// flush ack only with an accepted request
	assert property (@(posedge clk) disable iff (!resetn)
		flush_ack_o |-> fire)
		else $error("flush ack without acceptance");

	assert property (@(posedge clk) disable iff (!resetn)
		(fire & flush_req_i) |-> flush_ack_o)
		else $error("accepted flush request without ack");

endmodule

bind imem_fetch_ctrl imem_fetch_ctrl_chk u_chk (
	.clk               (clk),
	.resetn            (resetn),
	.rst_req_i         (rst_req_i),
	.flush_req_i       (flush_req_i),
	.rst_ack_o         (rst_ack_o),
	.flush_ack_o       (flush_ack_o),
	.imem_req_valid_o  (imem_req_valid_o),
	.imem_req_ready_i  (imem_req_ready_i),
	.imem_resp_valid_i (imem_resp_valid_i),
	.if_res_valid_o    (if_res_valid_o),
	.res_count_i       (res_count)
);

`default_nettype wire

// ==== testbench/tb_imem_fetch_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_imem_fetch_ctrl;

	import imem_bus_pkg::*;
	import fetch_pkg::*;

	localparam addr_t BOOT_ADDR  = 32'h0000_1000;
	localparam int    RAND_CYCLES = 3000;
	localparam int    HOLD_CYCLES = 40;
	localparam int    WAIT_LIMIT  = 200; // cycles per wait loop

	logic       clk;
	logic       resetn;
	logic       rst_req_i;
	logic       flush_req_i;
	addr_t      flush_addr_i;
	logic       rst_ack_o;
	logic       flush_ack_o;
	logic       to_rst_o;
	logic       to_flush_o;
	addr_t      flush_addr_hold_o;
	addr_t      now_pc_o;
	word_t      now_inst_o;
	addr_t      new_pc_i;
	logic       to_jump_i;
	addr_t      imem_req_addr_o;
	logic       imem_req_valid_o;
	logic       imem_req_ready_i;
	word_t      imem_resp_rdata_i;
	resp_err_t  imem_resp_err_i;
	logic       imem_resp_valid_i;
	fetch_res_t if_res_o;
	logic       if_res_valid_o;
	logic       if_res_ready_i;

	integer seed;
	int     cyc;

	// responder queue, one entry per accepted request
	addr_t     rq_addr[$];
	int        rq_gen[$]; // redirect generation at acceptance
	int        rq_due[$]; // cycle of the response
	resp_err_t rq_err[$];
	int        last_due;

	fetch_res_t exp_q[$]; // results the DUT should hold

	logic     m_rst_pend;
	logic     m_flush_pend;
	logic     m_wait; // good inst waiting for its next request
	addr_t    m_flush_tgt;
	addr_t    m_last_pc;
	word_t    m_last_good;
	inst_id_t m_id;
	int       m_gen;
	int       m_accepts;
	int       m_pops;

	imem_fetch_ctrl UUT (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	// memory contents follow the full address
	function automatic word_t mem_word(input addr_t a);
		return {a[15:0], ~a[31:16]} ^ 32'h3c96_a55a;
	endfunction

	task automatic fail_stop();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at cycle %0d", cyc);
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_addr(input string name, input addr_t act, input addr_t exp);
		if (act !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_word(input string name, input word_t act, input word_t exp);
		if (act !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, act, exp);
			fail_stop();
		end
	endtask

	task automatic check_res(input fetch_res_t act, input fetch_res_t exp);
		if (act !== exp)
		begin
			$display("** Error: if_res_o got %h expected %h", act, exp);
			fail_stop();
		end
	endtask

	// model update and checks, just before the rising edge
	task automatic sample_cycle();
		logic       rst_now;
		logic       flush_now;
		logic       good;
		logic       fire;
		logic [31:0] r;
		int         credits;
		int         due;
		addr_t      exp_pc;
		fetch_res_t rec;
		rst_now   = rst_req_i | m_rst_pend;
		flush_now = flush_req_i | m_flush_pend;
		credits   = rq_addr.size() + exp_q.size();
		good      = 1'b0;
		if (flush_req_i)
			m_flush_tgt = flush_addr_i;
		check_flag("to_rst_o", to_rst_o, rst_now);
		check_flag("to_flush_o", to_flush_o, flush_now);
		if (flush_now)
			check_addr("flush_addr_hold_o", flush_addr_hold_o, m_flush_tgt);
		if (m_accepts != 0)
			check_addr("now_pc_o", now_pc_o, m_last_pc); // last accepted address
		if (m_wait && !rst_now && !flush_now)
			check_word("now_inst_o", now_inst_o, m_last_good);
		// result leaves one cycle after its response
		check_flag("if_res_valid_o", if_res_valid_o,
			(exp_q.size() != 0) && !(rst_req_i | flush_req_i));
		if (if_res_valid_o && if_res_ready_i)
		begin
			check_res(if_res_o, exp_q[0]);
			void'(exp_q.pop_front());
			m_pops++;
		end
		if (rst_req_i | flush_req_i)
			exp_q.delete(); // held results are thrown away
		if (imem_resp_valid_i)
		begin
			good = (rq_gen[0] == m_gen) && !rst_now && !flush_now;
			if (good)
			begin
				rec.pc   = rq_addr[0];
				rec.inst = imem_resp_rdata_i;
				rec.err  = rq_err[0];
				rec.jump = to_jump_i;
				rec.id   = m_id;
				exp_q.push_back(rec);
				m_id        = m_id + inst_id_t'(1);
				m_last_good = imem_resp_rdata_i;
			end
			void'(rq_addr.pop_front());
			void'(rq_gen.pop_front());
			void'(rq_due.pop_front());
			void'(rq_err.pop_front());
		end
		check_flag("imem_req_valid_o", imem_req_valid_o,
			(credits < FETCH_BUF_DEPTH) && (rst_now | flush_now | good | m_wait));
		fire = imem_req_valid_o & imem_req_ready_i;
		check_flag("rst_ack_o", rst_ack_o, fire & rst_now);
		check_flag("flush_ack_o", flush_ack_o, fire & flush_now);
		if (fire)
		begin
			exp_pc = rst_now ? BOOT_ADDR : (flush_now ? m_flush_tgt : m_last_pc + 32'd4);
			check_addr("imem_req_addr_o", imem_req_addr_o, exp_pc);
			if (rst_now || flush_now)
				m_gen++; // everything older is now stale
			r   = rnd();
			due = cyc + 1 + int'(r[1:0] % 2'd3);
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			rq_addr.push_back(exp_pc);
			rq_gen.push_back(m_gen);
			rq_due.push_back(due);
			rq_err.push_back((exp_pc[3:2] == 2'b11) ? resp_err_t'(r[5:4]) : RESP_OK);
			m_last_pc = exp_pc;
			m_accepts++;
		end
		m_rst_pend = (m_rst_pend | rst_req_i) & ~fire;
		// a reset pulse cancels a waiting flush
		if (fire || rst_req_i)
			m_flush_pend = 1'b0;
		else if (flush_req_i)
			m_flush_pend = 1'b1;
		m_wait = (m_wait | good) & ~(rst_now | flush_now) & ~fire;
	endtask

	// one clock cycle of stimulus, responder and checks
	task automatic step(input logic force_rst, input logic pulses_on, input logic hold_res);
		logic [31:0] r;
		@(negedge clk);
		cyc++;
		r           = rnd();
		rst_req_i   = force_rst;
		flush_req_i = 1'b0;
		if (pulses_on && r[11:6] == 6'd0)
			rst_req_i = 1'b1;
		else if (pulses_on && r[11:6] == 6'd1)
		begin
			flush_req_i  = 1'b1;
			flush_addr_i = rnd() & 32'h0000_fffc;
		end
		imem_req_ready_i = (r[1:0] != 2'b00);
		if_res_ready_i   = hold_res ? 1'b0 : (r[2] | r[3]);
		to_jump_i        = r[4];
		if (rq_due.size() != 0 && rq_due[0] == cyc)
		begin
			imem_resp_valid_i = 1'b1;
			imem_resp_rdata_i = mem_word(rq_addr[0]);
			imem_resp_err_i   = rq_err[0];
		end
		else
		begin
			imem_resp_valid_i = 1'b0;
			imem_resp_rdata_i = rnd();
			imem_resp_err_i   = RESP_OK;
		end
		#1;
		// pc generator
		if (to_rst_o)
			new_pc_i = BOOT_ADDR;
		else if (to_flush_o)
			new_pc_i = flush_addr_hold_o;
		else
			new_pc_i = now_pc_o + 32'd4;
		#14;
		sample_cycle();
	endtask

	initial
	begin
		int waited;
		int target;
		seed              = 32'hf6c5;
		clk               = 1'b0;
		resetn            = 1'b0;
		rst_req_i         = 1'b0;
		flush_req_i       = 1'b0;
		flush_addr_i      = '0;
		new_pc_i          = '0;
		to_jump_i         = 1'b0;
		imem_req_ready_i  = 1'b0;
		imem_resp_rdata_i = '0;
		imem_resp_err_i   = RESP_OK;
		imem_resp_valid_i = 1'b0;
		if_res_ready_i    = 1'b0;
		cyc          = 0;
		last_due     = 0;
		m_rst_pend   = 1'b0;
		m_flush_pend = 1'b0;
		m_wait       = 1'b0;
		m_flush_tgt  = '0;
		m_last_pc    = '0;
		m_last_good  = '0;
		m_id         = '0;
		m_gen        = 0;
		m_accepts    = 0;
		m_pops       = 0;
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		// idle until the first reset request
		repeat (3) step(1'b0, 1'b0, 1'b0);
		step(1'b1, 1'b0, 1'b0);
		waited = 0;
		while (m_accepts == 0)
		begin
			if (waited == WAIT_LIMIT)
			begin
				$display("boot request was never accepted");
				fail_stop();
			end
			step(1'b0, 1'b0, 1'b0);
			waited++;
		end
		for (int i = 0; i < RAND_CYCLES; i++)
			step(1'b0, 1'b1, 1'b0);
		// decode stalled, buffer fills up
		for (int i = 0; i < HOLD_CYCLES; i++)
			step(1'b0, 1'b0, 1'b1);
		if (exp_q.size() != FETCH_BUF_DEPTH)
		begin
			$display("result buffer did not fill while decode was stalled");
			fail_stop();
		end
		target = m_pops + exp_q.size();
		waited = 0;
		while (m_pops < target)
		begin
			if (waited == WAIT_LIMIT)
			begin
				$display("buffered results did not drain after release");
				fail_stop();
			end
			step(1'b0, 1'b0, 1'b0);
			waited++;
		end
		if (m_pops > 0 && m_accepts > 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("no result was ever transferred");
			fail_stop();
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/imem_bus_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/fetch_req_ctrl.sv
verilog/fetch_resp_filter.sv
verilog/imem_fetch_ctrl.sv
testbench/imem_fetch_ctrl_chk.sv
testbench/tb_imem_fetch_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_imem_fetch_ctrl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
